// ==== Bender.yml ====
package:
  name: qpu_exu

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/qpu_exu_pkg.sv
      - design/qpu_exu_disp.sv
      - design/qpu_exu_timing_regs.sv
      - design/qpu_exu_event_queue.sv
      - design/qpu_exu.sv

  - target: test
    include_dirs:
      - design
    files:
      - test/tb_qpu_exu.sv

// ==== design/qpu_exu.sv ====
// Execution stage top with one instruction per cycle at most and a free-running i_trig_clk in clk domain
`timescale 1ns/100ps
`default_nettype none

`include "qpu_exu_params.svh"

module qpu_exu (
  input  wire                             clk,
  input  wire                             i_arst_n,
  input  wire                             i_valid,
  input  wire  [`QPU_INSTR_W-1:0]         i_instr,
  input  wire  [`QPU_TIME_W-1:0]          i_trig_clk,
  output logic                            o_ready,
  output logic                            o_illegal,
  output logic                            o_exu_active,
  output logic                            o_trig_clk_ena,
  output logic [`QPU_EVENT_NUM-1:0]       o_trig_valid,
  output logic [`QPU_EVENT_WIRE_W-1:0]    o_trig_data
);

  qpu_exu_pkg::exu_op_t       disp_op;
  qpu_exu_pkg::event_entry_t  evq_entry;
  logic                       evq_push;
  logic                       evq_full;

  ////////////////////
  // Dispatch
  qpu_exu_disp u_qpu_exu_disp (
    .clk          (clk       ),
    .i_arst_n     (i_arst_n  ),
    .i_valid      (i_valid   ),
    .i_instr      (i_instr   ),
    .i_queue_full (evq_full  ),
    .o_ready      (o_ready   ),
    .o_op         (disp_op   ),
    .o_illegal    (o_illegal )
  );

  ////////////////////
  // Time and channel data registers
  qpu_exu_timing_regs u_qpu_exu_timing_regs (
    .clk      (clk       ),
    .i_arst_n (i_arst_n  ),
    .i_op     (disp_op   ),
    .o_push   (evq_push  ),
    .o_entry  (evq_entry )
  );

  ////////////////////
  // Event queue and trigger release
  qpu_exu_event_queue u_qpu_exu_event_queue (
    .clk            (clk            ),
    .i_arst_n       (i_arst_n       ),
    .i_push         (evq_push       ),
    .i_entry        (evq_entry      ),
    .i_trig_clk     (i_trig_clk     ),
    .o_full         (evq_full       ),
    .o_trig_clk_ena (o_trig_clk_ena ),
    .o_trig_valid   (o_trig_valid   ),
    .o_trig_data    (o_trig_data    )
  );

  assign o_exu_active = o_trig_clk_ena | i_valid;  // Pending events or a waiting instruction

endmodule

`default_nettype wire

// ==== design/qpu_exu_disp.sv ====
// Ready follows queue space alone and illegal opcodes are consumed and flagged but never executed
`timescale 1ns/100ps
`default_nettype none

`include "qpu_exu_params.svh"

module qpu_exu_disp (
  input  wire                        clk,
  input  wire                        i_arst_n,
  input  wire                        i_valid,
  input  wire  [`QPU_INSTR_W-1:0]    i_instr,
  input  wire                        i_queue_full,
  output logic                       o_ready,
  output qpu_exu_pkg::exu_op_t       o_op,
  output logic                       o_illegal
);

  qpu_exu_pkg::opcode_e opc;
  logic                 legal;
  logic                 accept;

  ////////////////////
  // Decode
  assign opc = qpu_exu_pkg::opcode_e'(i_instr[`QPU_OPC_MSB:`QPU_OPC_LSB]);

  always_comb begin
    case (opc)
      qpu_exu_pkg::OPC_NOP,
      qpu_exu_pkg::OPC_TSET,
      qpu_exu_pkg::OPC_WAIT,
      qpu_exu_pkg::OPC_EDATA,
      qpu_exu_pkg::OPC_EVENT: legal = 1'b1;
      default:                legal = 1'b0;  // Codes 5 to 15
    endcase
  end

  // Handshake
  assign o_ready = ~i_queue_full;  // Same for every opcode
  assign accept  = i_valid & o_ready;

  always_comb begin
    o_op.strb = accept & legal;
    o_op.opc  = opc;
    o_op.mask = i_instr[`QPU_MASK_MSB:`QPU_MASK_LSB];
    o_op.imm  = i_instr[`QPU_IMM_W-1:0];
  end

  ////////////////////
  // Illegal flag pulses one cycle after the accept edge
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_illegal <= 1'b0;
    end else begin
      o_illegal <= accept & ~legal;
    end
  end

  // A stalled instruction stays on the input until it is accepted
  assert property (@(posedge clk) disable iff (!i_arst_n)
                   (i_valid && !o_ready) |=> (i_valid && $stable(i_instr)))
    else $error("instruction dropped or changed while stalled");

endmodule

`default_nettype wire

// ==== design/qpu_exu_event_queue.sv ====
// Releases at most one event per cycle in push order, and a late head holds back every entry behind it
`timescale 1ns/100ps
`default_nettype none

`include "qpu_exu_params.svh"

module qpu_exu_event_queue (
  input  wire                                clk,
  input  wire                                i_arst_n,
  input  wire                                i_push,
  input  wire qpu_exu_pkg::event_entry_t     i_entry,
  input  wire  [`QPU_TIME_W-1:0]             i_trig_clk,
  output logic                               o_full,
  output logic                               o_trig_clk_ena,
  output logic [`QPU_EVENT_NUM-1:0]          o_trig_valid,
  output logic [`QPU_EVENT_WIRE_W-1:0]       o_trig_data
);

  localparam int PTR_W = (`QPU_QUEUE_DEPTH > 1) ? $clog2(`QPU_QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(`QPU_QUEUE_DEPTH + 1);

  qpu_exu_pkg::event_entry_t mem_q [`QPU_QUEUE_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  qpu_exu_pkg::event_entry_t head;
  logic                      empty;
  logic                      pop;

  ////////////////////
  // Storage
  always_ff @(posedge clk) begin
    if (i_push) begin
      mem_q[wr_ptr_q] <= i_entry;
    end
  end

  assign head   = mem_q[rd_ptr_q];
  assign empty  = (count_q == '0);
  assign o_full = (count_q == CNT_W'(`QPU_QUEUE_DEPTH));

  // Release on match or once the trigger clock has passed
  assign pop = !empty && (head.tpoint <= i_trig_clk);

  ////////////////////
  // Pointers and count
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (i_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(`QPU_QUEUE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(`QPU_QUEUE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({i_push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Both or neither
      endcase
    end
  end

  assign o_trig_clk_ena = ~empty;

  ////////////////////
  // Release outputs pulse for one cycle after the pop edge
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_trig_valid <= '0;
      o_trig_data  <= '0;
    end else if (pop) begin
      o_trig_valid <= head.mask;
      o_trig_data  <= head.data;
    end else begin
      o_trig_valid <= '0;
      o_trig_data  <= '0;
    end
  end

  // Dispatch holds ready low while full
  assert property (@(posedge clk) disable iff (!i_arst_n) o_full |-> !i_push)
    else $error("event pushed into a full queue");

endmodule

`default_nettype wire

// ==== design/qpu_exu_params.svh ====
// Field positions assume a 32-bit instruction word. QPU_EVENT_DW must not exceed QPU_IMM_W
`ifndef QPU_EXU_PARAMS_SVH
`define QPU_EXU_PARAMS_SVH

////////////////////
// Instruction word fields
`define QPU_INSTR_W 32
`define QPU_OPC_MSB 31
`define QPU_OPC_LSB 28
`define QPU_MASK_MSB 27
`define QPU_MASK_LSB 24
// Immediate sits in the low bits of the word
`define QPU_IMM_W 16

////////////////////
// Time points and event channels
`define QPU_TIME_W 16
// One mask bit per channel
`define QPU_EVENT_NUM 4
`define QPU_EVENT_DW 8
`define QPU_EVENT_WIRE_W (`QPU_EVENT_NUM * `QPU_EVENT_DW)

// Scheduled events held at once
`define QPU_QUEUE_DEPTH 4

`endif

// ==== design/qpu_exu_pkg.sv ====
// Types shared by the execution stage. Widths come from the params header and are not checked here
`default_nettype none

`include "qpu_exu_params.svh"

package qpu_exu_pkg;

  ////////////////////
  // Opcodes, anything not listed is illegal
  typedef enum logic [`QPU_OPC_MSB-`QPU_OPC_LSB:0] {
    OPC_NOP   = 4'd0,
    OPC_TSET  = 4'd1,  // Load time register
    OPC_WAIT  = 4'd2,  // Advance time register
    OPC_EDATA = 4'd3,  // Write channel data
    OPC_EVENT = 4'd4   // Schedule at current time
  } opcode_e;

  // Accepted instruction from dispatch
  typedef struct packed {
    logic                      strb;  // One cycle per legal accept
    opcode_e                   opc;
    logic [`QPU_EVENT_NUM-1:0] mask;
    logic [`QPU_IMM_W-1:0]     imm;
  } exu_op_t;

  ////////////////////
  // One scheduled event
  typedef struct packed {
    logic [`QPU_TIME_W-1:0]       tpoint;
    logic [`QPU_EVENT_NUM-1:0]    mask;
    logic [`QPU_EVENT_WIRE_W-1:0] data;  // Channel 0 in the low byte
  } event_entry_t;

endpackage

`default_nettype wire

// ==== design/qpu_exu_timing_regs.sv ====
// Time register wraps at QPU_TIME_W bits and the queue compares unwrapped, so keep schedules below the wrap
`timescale 1ns/100ps
`default_nettype none

`include "qpu_exu_params.svh"

module qpu_exu_timing_regs (
  input  wire                         clk,
  input  wire                         i_arst_n,
  input  wire qpu_exu_pkg::exu_op_t   i_op,
  output logic                        o_push,
  output qpu_exu_pkg::event_entry_t   o_entry
);

  logic [`QPU_TIME_W-1:0]                        time_q;
  logic [`QPU_EVENT_NUM-1:0][`QPU_EVENT_DW-1:0]  chan_q;  // Channel 0 in the lowest byte

  logic is_tset;
  logic is_wait;
  logic is_edata;
  logic is_event;

  assign is_tset  = i_op.strb && (i_op.opc == qpu_exu_pkg::OPC_TSET);
  assign is_wait  = i_op.strb && (i_op.opc == qpu_exu_pkg::OPC_WAIT);
  assign is_edata = i_op.strb && (i_op.opc == qpu_exu_pkg::OPC_EDATA);
  assign is_event = i_op.strb && (i_op.opc == qpu_exu_pkg::OPC_EVENT);

  ////////////////////
  // Time register
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      time_q <= '0;
    end else if (is_tset) begin
      time_q <= i_op.imm;
    end else if (is_wait) begin
      time_q <= time_q + i_op.imm;  // Wraps
    end
  end

  // Every masked channel takes the low byte of the immediate
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      chan_q <= '0;
    end else if (is_edata) begin
      for (int i = 0; i < `QPU_EVENT_NUM; i++) begin
        if (i_op.mask[i]) begin
          chan_q[i] <= i_op.imm[`QPU_EVENT_DW-1:0];
        end
      end
    end
  end

  ////////////////////
  // Queue push at the accept edge with pre-edge values
  assign o_push = is_event;

  always_comb begin
    o_entry.tpoint = time_q;
    o_entry.mask   = i_op.mask;
    o_entry.data   = chan_q;
  end

  // Dispatch strobes only the five legal opcodes
  assert property (@(posedge clk) disable iff (!i_arst_n)
                   i_op.strb |-> (i_op.opc <= qpu_exu_pkg::OPC_EVENT))
    else $error("operation strobe with an illegal opcode");

endmodule

`default_nettype wire

// ==== test/tb_qpu_exu.sv ====
// Directed and seeded random tests of qpu_exu; assumes time points stay below the 16-bit wrap
`timescale 1ns/100ps
`default_nettype none

`include "qpu_exu_params.svh"

module tb_qpu_exu;

  // Six tests with about 200 random instructions and their stalls stay far below this
  localparam int TIMEOUT_CYCLES = 20000;
  localparam int RAND_INSTRS    = 200;

  logic                          clk;
  logic                          i_arst_n;
  logic                          i_valid;
  logic [`QPU_INSTR_W-1:0]       i_instr;
  logic [`QPU_TIME_W-1:0]        i_trig_clk;
  logic                          o_ready;
  logic                          o_illegal;
  logic                          o_exu_active;
  logic                          o_trig_clk_ena;
  logic [`QPU_EVENT_NUM-1:0]     o_trig_valid;
  logic [`QPU_EVENT_WIRE_W-1:0]  o_trig_data;

  ////////////////////
  // Reference model state
  logic [`QPU_TIME_W-1:0]        m_time;
  logic [`QPU_EVENT_WIRE_W-1:0]  m_chan;  // Channel 0 in the low byte
  qpu_exu_pkg::event_entry_t     exp_q[$];
  qpu_exu_pkg::event_entry_t     mon_entry;

  // Released pulses seen in the current test
  logic [`QPU_EVENT_NUM-1:0]     seen_mask[$];
  logic [`QPU_EVENT_WIRE_W-1:0]  seen_data[$];
  logic [`QPU_TIME_W-1:0]        seen_trig[$];
  logic [`QPU_TIME_W-1:0]        trig_at_edge;  // i_trig_clk at the last rising edge

  string cur_test;
  int    err_cnt;
  int    chk_cnt;
  int    test_cnt;
  int    err_at_start;
  int    cycle_cnt;
  int    trig_step;   // 0 holds i_trig_clk
  bit    trig_rand;

  qpu_exu dut0 (
    .clk            (clk           ),
    .i_arst_n       (i_arst_n      ),
    .i_valid        (i_valid       ),
    .i_instr        (i_instr       ),
    .i_trig_clk     (i_trig_clk    ),
    .o_ready        (o_ready       ),
    .o_illegal      (o_illegal     ),
    .o_exu_active   (o_exu_active  ),
    .o_trig_clk_ena (o_trig_clk_ena),
    .o_trig_valid   (o_trig_valid  ),
    .o_trig_data    (o_trig_data   )
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles in test %s", cycle_cnt, cur_test);
      $display("TB FAILED");
      $finish;
    end
  end

  task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
    chk_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("Fail %s (%s): expected 0x%0h, actual 0x%0h", cur_test, what, exp, act);
    end
  endtask

  ////////////////////
  // Pulse monitor samples on the falling edge where outputs are settled
  always @(negedge clk) begin
    if (i_arst_n && (o_trig_valid != '0)) begin
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("%s: trigger pulse seen with no event scheduled", cur_test);
      end else begin
        mon_entry = exp_q.pop_front();
        check("pulse mask", mon_entry.mask, o_trig_valid);
        check("pulse data", mon_entry.data, o_trig_data);
        if (trig_at_edge < mon_entry.tpoint) begin
          err_cnt++;
          $display("%s: event for time %0d released at trigger clock %0d", cur_test,
                   mon_entry.tpoint, trig_at_edge);
        end
      end
      seen_mask.push_back(o_trig_valid);
      seen_data.push_back(o_trig_data);
      seen_trig.push_back(trig_at_edge);
    end
    trig_at_edge = i_trig_clk;  // Held through the next rising edge
  end

  function automatic logic [`QPU_INSTR_W-1:0] make_instr(input logic [3:0] opc,
      input logic [3:0] mask, input logic [15:0] imm);
    logic [`QPU_INSTR_W-1:0] w;
    w = '0;
    w[`QPU_OPC_MSB:`QPU_OPC_LSB]   = opc;
    w[`QPU_MASK_MSB:`QPU_MASK_LSB] = mask;
    w[`QPU_IMM_W-1:0]              = imm;
    return w;
  endfunction

  // Model effect of one accepted instruction
  function automatic void model_accept(input logic [`QPU_INSTR_W-1:0] w);
    logic [3:0]                opc;
    logic [3:0]                mask;
    logic [15:0]               imm;
    qpu_exu_pkg::event_entry_t e;
    opc  = w[`QPU_OPC_MSB:`QPU_OPC_LSB];
    mask = w[`QPU_MASK_MSB:`QPU_MASK_LSB];
    imm  = w[`QPU_IMM_W-1:0];
    case (opc)
      4'd1: m_time = imm;
      4'd2: m_time = m_time + imm;  // Wraps at 16 bits
      4'd3: begin
        for (int ch = 0; ch < `QPU_EVENT_NUM; ch++) begin
          if (mask[ch]) m_chan[ch*`QPU_EVENT_DW +: `QPU_EVENT_DW] = imm[`QPU_EVENT_DW-1:0];
        end
      end
      4'd4: begin
        e.tpoint = m_time;
        e.mask   = mask;
        e.data   = m_chan;
        exp_q.push_back(e);
      end
      default: ;  // NOP and illegal codes
    endcase
  endfunction

  // One cycle with inputs changing 1 ns after the edge
  task automatic tick();
    @(posedge clk);
    #1;
    if (trig_step != 0) begin
      if (trig_rand) i_trig_clk = i_trig_clk + 16'($urandom_range(trig_step));
      else i_trig_clk = i_trig_clk + 16'(trig_step);
    end
  endtask

  task automatic send_instr(input logic [3:0] opc, input logic [3:0] mask,
                            input logic [15:0] imm);
    logic [`QPU_INSTR_W-1:0] w;
    w       = make_instr(opc, mask, imm);
    i_instr = w;
    i_valid = 1'b1;
    while (!o_ready) tick();
    tick();  // Accept edge
    model_accept(w);
    check("illegal flag", opc > 4'd4, o_illegal);
    check("active with valid", 1, o_exu_active);
    i_valid = 1'b0;
  endtask

  task automatic start_test(input string name);
    cur_test     = name;
    err_at_start = err_cnt;
    seen_mask.delete();
    seen_data.delete();
    seen_trig.delete();
  endtask

  task automatic end_test();
    check("model queue left", 0, exp_q.size());
    test_cnt++;
    $display("%s: %0d errors", cur_test, err_cnt - err_at_start);
  endtask

  ////////////////////
  // Tests
  task automatic test_after_reset();
    start_test("after_reset");
    check("ready", 1, o_ready);
    check("trig valid", 0, o_trig_valid);
    check("trig data", 0, o_trig_data);
    check("trig clk ena", 0, o_trig_clk_ena);
    check("illegal", 0, o_illegal);
    check("exu active", 0, o_exu_active);
    end_test();
  endtask

  task automatic test_single_event();
    start_test("single_event");
    i_trig_clk = 16'd50;
    send_instr(4'd1, 4'h0, 16'd100);
    send_instr(4'd3, 4'b0011, 16'h005a);
    send_instr(4'd4, 4'b0001, 16'h0000);
    i_trig_clk = 16'd99;
    repeat (10) begin
      check("clk ena while pending", 1, o_trig_clk_ena);
      tick();
    end
    check("pulses before time", 0, seen_mask.size());
    i_trig_clk = 16'd100;
    while (exp_q.size() != 0) tick();
    check("pulse count", 1, seen_mask.size());
    check("mask", 4'b0001, seen_mask[0]);
    check("data", 32'h0000_5a5a, seen_data[0]);
    check("clk ena after release", 0, o_trig_clk_ena);
    check("trig valid after pulse", 0, o_trig_valid);
    end_test();
  endtask

  task automatic test_wait_accum();
    start_test("wait_accum");
    i_trig_clk = '0;
    send_instr(4'd1, 4'h0, 16'd10);
    send_instr(4'd4, 4'h1, 16'd0);
    send_instr(4'd2, 4'h0, 16'd5);
    send_instr(4'd4, 4'h2, 16'd0);
    send_instr(4'd2, 4'h0, 16'd7);
    send_instr(4'd4, 4'h4, 16'd0);
    trig_step = 1;  // Count up one per cycle
    while (exp_q.size() != 0) tick();
    trig_step = 0;
    check("pulse count", 3, seen_mask.size());
    if (seen_mask.size() == 3) begin
      check("first mask", 4'h1, seen_mask[0]);
      check("second mask", 4'h2, seen_mask[1]);
      check("third mask", 4'h4, seen_mask[2]);
      check("first release time", 16'd10, seen_trig[0]);
      check("second release time", 16'd15, seen_trig[1]);
      check("third release time", 16'd22, seen_trig[2]);
    end
    end_test();
  endtask

  task automatic test_back_pressure();
    start_test("back_pressure");
    i_trig_clk = '0;
    send_instr(4'd1, 4'h0, 16'd1000);
    for (int n = 1; n <= 4; n++) begin
      send_instr(4'd4, 4'(n), 16'd0);
    end
    check("ready when full", 0, o_ready);
    i_instr = make_instr(4'd4, 4'h5, 16'd0);
    i_valid = 1'b1;
    repeat (5) begin
      check("ready held low", 0, o_ready);
      check("active while full", 1, o_exu_active);
      tick();
    end
    i_trig_clk = 16'd1001;
    send_instr(4'd4, 4'h5, 16'd0);  // Fifth is accepted once a slot frees
    if (seen_mask.size() == 0) begin
      err_cnt++;
      $display("%s: fifth event accepted before any release", cur_test);
    end
    while (o_trig_clk_ena) begin
      check("active while draining", 1, o_exu_active);
      tick();
    end
    check("active when idle", 0, o_exu_active);
    tick();
    check("pulse count", 5, seen_mask.size());
    for (int n = 0; n < seen_mask.size(); n++) begin
      check("release order", 4'(n + 1), seen_mask[n]);
    end
    end_test();
  endtask

  task automatic test_illegal();
    start_test("illegal_opcode");
    i_trig_clk = 16'd2000;
    send_instr(4'd1, 4'h0, 16'd3000);
    send_instr(4'd3, 4'hf, 16'h0033);
    send_instr(4'hf, 4'hf, 16'h1234);  // Checks the pulse on return
    tick();
    check("illegal pulse length", 0, o_illegal);
    send_instr(4'd4, 4'hf, 16'd0);
    i_trig_clk = 16'd2999;
    repeat (4) tick();
    check("early pulses", 0, seen_mask.size());
    i_trig_clk = 16'd3000;
    while (exp_q.size() != 0) tick();
    check("pulse count", 1, seen_mask.size());
    check("data unchanged", 32'h3333_3333, seen_data[0]);
    check("time unchanged", 16'd3000, seen_trig[0]);
    end_test();
  endtask

  task automatic test_random();
    int kind;
    start_test("random_sequence");
    i_trig_clk = 16'd5000;
    send_instr(4'd1, 4'h0, 16'd5000);
    trig_step = 2;
    trig_rand = 1'b1;
    for (int n = 0; n < RAND_INSTRS; n++) begin
      kind = $urandom_range(4);
      case (kind)
        1:       send_instr(4'd1, 4'h0, i_trig_clk + 16'($urandom_range(40)));
        2:       send_instr(4'd2, 4'h0, 16'($urandom_range(12)));
        3:       send_instr(4'd3, 4'($urandom), 16'($urandom));
        4:       send_instr(4'd4, 4'($urandom_range(15, 1)), 16'($urandom));
        default: send_instr(4'd0, 4'($urandom), 16'($urandom));
      endcase
      repeat ($urandom_range(2)) tick();
    end
    while (exp_q.size() != 0) tick();
    trig_step = 0;
    check("clk ena at end", 0, o_trig_clk_ena);
    end_test();
  endtask

  initial begin
    void'($urandom(32'h7e9d_80f8));
    i_arst_n   = 1'b0;
    i_valid    = 1'b0;
    i_instr    = '0;
    i_trig_clk = '0;
    m_time     = '0;
    m_chan     = '0;
    trig_step  = 0;
    trig_rand  = 1'b0;
    cur_test   = "reset";
    repeat (16) @(posedge clk);
    #1;
    i_arst_n = 1'b1;
    test_after_reset();
    test_single_event();
    test_wait_accum();
    test_back_pressure();
    test_illegal();
    test_random();
    $display("Tests: %0d, checks: %0d, errors: %0d", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+design
design/qpu_exu_pkg.sv
design/qpu_exu_disp.sv
design/qpu_exu_timing_regs.sv
design/qpu_exu_event_queue.sv
design/qpu_exu.sv
test/tb_qpu_exu.sv
